//--- Makefile
VERILATOR ?= verilator
TOP       ?= fp_slice_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Finished with no errors

SOURCES := $(wildcard common/*.sv common/*.svh source/*.sv lane/*.sv verif/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- common/fp_format_pkg.sv
// Floating-point formats, status flags and NaN and sign classification helpers
`include "fp_slice_config.svh"

package fp_format_pkg;

  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  localparam int unsigned FP32_WIDTH = 32;
  localparam int unsigned FP16_WIDTH = 16;

  typedef logic [`SLICE_WIDTH-1:0] lane_word_t;  // FP16 uses the low half

  typedef struct packed {
    logic nv;  // Invalid
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  function automatic int unsigned fp_width(fp_format_e fmt);
    return (fmt == FP32) ? FP32_WIDTH : FP16_WIDTH;
  endfunction

  function automatic logic sign_bit(lane_word_t val, fp_format_e fmt);
    return (fmt == FP32) ? val[FP32_WIDTH-1] : val[FP16_WIDTH-1];
  endfunction

  // Exponent all ones with the quiet bit set
  function automatic logic is_qnan(lane_word_t val, fp_format_e fmt);
    if (fmt == FP32) begin
      return (&val[30:23]) & val[22];
    end
    return (&val[14:10]) & val[9];
  endfunction

  // Exponent all ones, quiet bit clear, nonzero payload
  function automatic logic is_snan(lane_word_t val, fp_format_e fmt);
    if (fmt == FP32) begin
      return (&val[30:23]) & ~val[22] & (|val[21:0]);
    end
    return (&val[14:10]) & ~val[9] & (|val[8:0]);
  endfunction

  function automatic logic is_nan(lane_word_t val, fp_format_e fmt);
    return is_qnan(val, fmt) | is_snan(val, fmt);
  endfunction

  function automatic lane_word_t canonical_nan(fp_format_e fmt);
    return (fmt == FP32) ? 32'h7fc0_0000 : 32'hffff_7e00;  // FP16 comes NaN-boxed
  endfunction

endpackage

//--- common/fp_slice_config.svh
// Build-time configuration of the SIMD floating-point slice
`ifndef FP_SLICE_CONFIG_SVH
`define FP_SLICE_CONFIG_SVH

// --------------------
// Datapath
// --------------------
`define SLICE_WIDTH 32     // One FP32 lane or two FP16 lanes
`define NUM_LANES 2

// --------------------
// Pipeline and tagging
// --------------------
// Register stages per lane, 0 to 3 are supported
`define NUM_PIPE_REGS 1
`define TAG_BITS 4         // Operation tag travelling with lane 0

`endif

//--- common/lane_if.sv
// Lane request and response channels between decode, lanes and result packing
`timescale 1ns/1ps

interface lane_req_if import fp_format_pkg::*; import slice_op_pkg::*; ();

  logic       valid;
  logic       ready;
  lane_word_t operand_a;
  lane_word_t operand_b;
  operation_e op;
  logic       mask;
  lane_aux_t  aux;

  // Decode side
  modport source (output valid, operand_a, operand_b, op, mask, aux, input ready);
  // Lane side
  modport sink (input valid, operand_a, operand_b, op, mask, aux, output ready);

endinterface

interface lane_rsp_if import fp_format_pkg::*; import slice_op_pkg::*; ();

  logic       valid;
  logic       ready;
  lane_word_t result;
  status_t    status;
  logic       mask;
  lane_aux_t  aux;

  // Lane side
  modport source (output valid, result, status, mask, aux, input ready);
  // Packer side
  modport sink (input valid, result, status, mask, aux, output ready);

endinterface

//--- common/slice_op_pkg.sv
// Operation encoding and the per-lane records carried through the slice pipeline
`include "fp_slice_config.svh"

package slice_op_pkg;

  import fp_format_pkg::*;

  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    MIN   = 3'd3,
    MAX   = 3'd4
  } operation_e;

  // Travels next to the data so the packer knows how to assemble the result
  typedef struct packed {
    fp_format_e fmt;
    logic       vectorial;
  } lane_aux_t;

  typedef struct packed {
    lane_word_t result;
    status_t    status;
    logic       mask;     // SIMD mask bit of this lane
    lane_aux_t  aux;
  } lane_payload_t;

  typedef logic [`TAG_BITS-1:0] tag_t;

endpackage

//--- compile.f
+incdir+common
common/fp_format_pkg.sv
common/slice_op_pkg.sv
common/lane_if.sv
lane/lane_pipe.sv
lane/fp_lane.sv
source/slice_decode.sv
source/slice_result.sv
source/fp_slice_top.sv
verif/fp_slice_sva.sv
verif/fp_slice_tb.sv

//--- lane/fp_lane.sv
// One SIMD lane computing sign injection or min/max followed by its pipeline
`timescale 1ns/1ps
`include "fp_slice_config.svh"

module fp_lane import fp_format_pkg::*; import slice_op_pkg::*; #(
  parameter int unsigned LaneIdx = 0
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  lane_req_if.sink   req_i,
  lane_rsp_if.source rsp_o,
  output logic       busy_o
);

  fp_format_e    lane_fmt;
  logic          sign_a;
  logic          sign_b;
  logic          res_sign;
  logic [30:0]   mag_a;
  logic [30:0]   mag_b;
  logic          nan_a;
  logic          nan_b;
  logic          a_lt_b;
  logic          is_minmax;
  lane_word_t    sgnj_word;
  lane_word_t    minmax_word;
  status_t       op_status;
  lane_payload_t pipe_in;
  lane_payload_t pipe_out;

  // Upper lanes only ever carry FP16
  assign lane_fmt = (LaneIdx == 0) ? req_i.aux.fmt : FP16;

  assign sign_a = sign_bit(req_i.operand_a, lane_fmt);
  assign sign_b = sign_bit(req_i.operand_b, lane_fmt);
  assign mag_a  = (lane_fmt == FP32) ? req_i.operand_a[30:0] : {16'h0, req_i.operand_a[14:0]};
  assign mag_b  = (lane_fmt == FP32) ? req_i.operand_b[30:0] : {16'h0, req_i.operand_b[14:0]};
  assign nan_a  = is_nan(req_i.operand_a, lane_fmt);
  assign nan_b  = is_nan(req_i.operand_b, lane_fmt);

  // --------------------
  // Sign injection
  // --------------------
  always_comb begin
    case (req_i.op)
      SGNJN:   res_sign = ~sign_b;
      SGNJX:   res_sign = sign_a ^ sign_b;
      default: res_sign = sign_b;
    endcase
  end

  assign sgnj_word = (lane_fmt == FP32) ? {res_sign, req_i.operand_a[30:0]}
                                        : {16'hffff, res_sign, req_i.operand_a[14:0]};

  // --------------------
  // Min / max
  // --------------------
  // Sign decides first, so -0 orders below +0
  assign a_lt_b = (sign_a != sign_b) ? sign_a : (sign_a ? (mag_a > mag_b) : (mag_a < mag_b));

  always_comb begin
    if (nan_a && nan_b) begin
      minmax_word = canonical_nan(lane_fmt);
    end else if (nan_a) begin
      minmax_word = req_i.operand_b;  // NaN loses against a number
    end else if (nan_b) begin
      minmax_word = req_i.operand_a;
    end else if ((req_i.op == MIN) == a_lt_b) begin
      minmax_word = req_i.operand_a;
    end else begin
      minmax_word = req_i.operand_b;
    end
    if (lane_fmt == FP16) begin
      minmax_word[31:16] = '1;
    end
  end

  assign is_minmax = (req_i.op == MIN) || (req_i.op == MAX);

  always_comb begin
    op_status    = '0;
    op_status.nv = is_minmax & (is_snan(req_i.operand_a, lane_fmt) |
                                is_snan(req_i.operand_b, lane_fmt));
  end

  assign pipe_in = '{result: is_minmax ? minmax_word : sgnj_word,
                     status: op_status, mask: req_i.mask, aux: req_i.aux};

  lane_pipe #(
    .PayloadType (lane_payload_t),
    .NumRegs     (`NUM_PIPE_REGS)
  ) i_lane_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (req_i.valid),
    .in_ready_o  (req_i.ready),
    .in_data_i   (pipe_in),
    .out_valid_o (rsp_o.valid),
    .out_ready_i (rsp_o.ready),
    .out_data_o  (pipe_out),
    .busy_o      (busy_o)
  );

  assign rsp_o.result = pipe_out.result;
  assign rsp_o.status = pipe_out.status;
  assign rsp_o.mask   = pipe_out.mask;
  assign rsp_o.aux    = pipe_out.aux;

endmodule

//--- lane/lane_pipe.sv
// Valid/ready register chain for any payload type
`timescale 1ns/1ps

module lane_pipe #(
  parameter type         PayloadType = logic,
  parameter int unsigned NumRegs     = 1
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  PayloadType in_data_i,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output PayloadType out_data_o,
  output logic       busy_o
);

  // Index i holds the item after i register stages
  logic [NumRegs:0] stage_valid;
  logic [NumRegs:0] stage_ready;
  PayloadType       stage_data [NumRegs+1];

  assign stage_valid[0] = in_valid_i;
  assign stage_data[0]  = in_data_i;
  assign in_ready_o     = stage_ready[0];

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic       valid_q;
    PayloadType data_q;

    // Advance when the next stage moves on or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[i] && stage_valid[i]) begin
        data_q <= stage_data[i];
      end
    end

    assign stage_valid[i+1] = valid_q;
    assign stage_data[i+1]  = data_q;
  end

  assign stage_ready[NumRegs] = out_ready_i;  // Driven by downstream
  assign out_valid_o          = stage_valid[NumRegs];
  assign out_data_o           = stage_data[NumRegs];
  assign busy_o               = |(stage_valid >> 1);  // Registered stages only
endmodule

//--- source/fp_slice_top.sv
// SIMD floating-point slice with sign injection and min/max on FP32 or 2x FP16
`timescale 1ns/1ps
`include "fp_slice_config.svh"

module fp_slice_top import fp_format_pkg::*; import slice_op_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  lane_word_t            operand_a_i,
  input  lane_word_t            operand_b_i,
  input  operation_e            op_i,
  input  fp_format_e            fmt_i,
  input  logic                  vectorial_op_i,
  input  logic [`NUM_LANES-1:0] simd_mask_i,
  input  tag_t                  tag_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output lane_word_t            result_o,
  output status_t               status_o,
  output tag_t                  tag_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);

  logic [`NUM_LANES-1:0] lane_busy;

  lane_req_if lane_req [`NUM_LANES] ();
  lane_rsp_if lane_rsp [`NUM_LANES] ();

  slice_decode i_slice_decode (
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .op_i           (op_i),
    .fmt_i          (fmt_i),
    .vectorial_op_i (vectorial_op_i),
    .simd_mask_i    (simd_mask_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .req_o          (lane_req)
  );

  for (genvar lane = 0; lane < `NUM_LANES; lane++) begin : gen_lanes
    fp_lane #(
      .LaneIdx (lane)
    ) i_fp_lane (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (lane_req[lane]),
      .rsp_o   (lane_rsp[lane]),
      .busy_o  (lane_busy[lane])
    );
  end

  // Tag runs beside lane 0 with the same handshake
  lane_pipe #(
    .PayloadType (tag_t),
    .NumRegs     (`NUM_PIPE_REGS)
  ) i_tag_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (),
    .in_data_i   (tag_i),
    .out_valid_o (),
    .out_ready_i (out_ready_i),
    .out_data_o  (tag_o),
    .busy_o      ()
  );

  slice_result i_slice_result (
    .rsp_i       (lane_rsp),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o)
  );

  assign busy_o = |lane_busy;

endmodule

//--- source/slice_decode.sv
// Slice decode that splits operands into lanes and issues per-lane requests
`timescale 1ns/1ps
`include "fp_slice_config.svh"

module slice_decode import fp_format_pkg::*; import slice_op_pkg::*; (
  input  lane_word_t             operand_a_i,
  input  lane_word_t             operand_b_i,
  input  operation_e             op_i,
  input  fp_format_e             fmt_i,
  input  logic                   vectorial_op_i,
  input  logic [`NUM_LANES-1:0]  simd_mask_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  lane_req_if.source             req_o [`NUM_LANES]
);

  logic      vector_op;
  logic      lane0_ready;
  lane_aux_t aux_data;

  // Only FP16 can be split, a vectorial FP32 request runs as scalar
  assign vector_op = vectorial_op_i & (fmt_i == FP16);

  assign aux_data = '{fmt: fmt_i, vectorial: vector_op};

  assign lane0_ready = req_o[0].ready;
  assign in_ready_o  = lane0_ready;  // Upstream follows lane 0

  // --------------------
  // Lane requests
  // --------------------
  for (genvar lane = 0; lane < `NUM_LANES; lane++) begin : gen_lane_req
    localparam int unsigned LANE = unsigned'(lane);

    // Upper lanes only for vectors and only together with lane 0
    if (lane == 0) begin : gen_first
      assign req_o[lane].valid = in_valid_i;
    end else begin : gen_upper
      assign req_o[lane].valid = in_valid_i & vector_op & lane0_ready;
    end

    // Move this lane's element down to bit 0, the lane ignores upper bits
    assign req_o[lane].operand_a = operand_a_i >> (LANE * fp_width(fmt_i));
    assign req_o[lane].operand_b = operand_b_i >> (LANE * fp_width(fmt_i));

    assign req_o[lane].op   = op_i;
    assign req_o[lane].mask = simd_mask_i[lane];
    assign req_o[lane].aux  = aux_data;
  end

endmodule

//--- source/slice_result.sv
// Result packer that assembles lane results by format and collapses status
`timescale 1ns/1ps
`include "fp_slice_config.svh"

module slice_result import fp_format_pkg::*; import slice_op_pkg::*; (
  lane_rsp_if.sink      rsp_i [`NUM_LANES],
  input  logic          out_ready_i,
  output lane_word_t    result_o,
  output status_t       status_o,
  output logic          out_valid_o
);

  lane_word_t                     lane_result [`NUM_LANES];
  status_t    [`NUM_LANES-1:0]    lane_status;
  logic       [`NUM_LANES-1:0]    lane_mask;
  logic       [`NUM_LANES-1:0]    lane_valid;
  lane_aux_t                      result_aux;

  // Lane 0 always carries the packing information
  assign result_aux = rsp_i[0].aux;

  for (genvar lane = 0; lane < `NUM_LANES; lane++) begin : gen_lane_rsp
    logic lane_used;

    // Upper lanes only take part in vector results
    assign lane_used = (lane == 0) | result_aux.vectorial;

    assign lane_result[lane] = rsp_i[lane].result;
    assign lane_status[lane] = rsp_i[lane].status;
    assign lane_mask[lane]   = rsp_i[lane].mask;
    assign lane_valid[lane]  = rsp_i[lane].valid & lane_used;
    assign rsp_i[lane].ready = out_ready_i & lane_used;
  end

  // --------------------
  // Result packing
  // --------------------
  always_comb begin
    if (result_aux.fmt == FP32) begin
      result_o = lane_result[0];
    end else begin
      result_o = '1;  // NaN-box whatever stays unused
      for (int i = 0; i < `NUM_LANES; i++) begin
        if (i == 0 || result_aux.vectorial) begin
          result_o[i*FP16_WIDTH +: FP16_WIDTH] = lane_result[i][FP16_WIDTH-1:0];
        end
      end
    end
  end

  // Status of masked-out or idle lanes is dropped
  always_comb begin
    status_o = '0;
    for (int i = 0; i < `NUM_LANES; i++) begin
      status_o |= lane_status[i] & {5{lane_mask[i] & lane_valid[i]}};
    end
  end

  assign out_valid_o = lane_valid[0];

endmodule

//--- verif/fp_slice_sva.sv
// Handshake and reset assertions for the SIMD floating-point slice
`timescale 1ns/1ps

module fp_slice_sva import fp_format_pkg::*; import slice_op_pkg::*; (
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       in_ready_o,
  input logic       out_valid_o,
  input logic       out_ready_i,
  input lane_word_t result_o,
  input status_t    status_o,
  input tag_t       tag_o,
  input logic       busy_o
);

  int unsigned failed_checks = 0;  // Collected by the testbench at the end

  // --------------------
  // Reset
  // --------------------
  reset_no_valid: assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_o)
    else begin
      $error("out_valid_o is high while reset is active");
      failed_checks++;
    end

  // --------------------
  // Handshake
  // --------------------
  // A stalled result keeps its value and tag
  stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o) &&
                                      $stable(status_o) && $stable(tag_o))
    else begin
      $error("Output changed while stalled by back-pressure");
      failed_checks++;
    end

  idle_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i) !busy_o |-> in_ready_o)
    else begin
      $error("in_ready_o is low while the slice is idle");
      failed_checks++;
    end

endmodule

bind fp_slice_top fp_slice_sva i_sva (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .in_ready_o  (in_ready_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .result_o    (result_o),
  .status_o    (status_o),
  .tag_o       (tag_o),
  .busy_o      (busy_o)
);

//--- verif/fp_slice_tb.sv
// Testbench for the SIMD floating-point slice with reference model and in-order scoreboard
`timescale 1ns/1ps
`include "fp_slice_config.svh"

module fp_slice_tb import fp_format_pkg::*; import slice_op_pkg::*; ();

  localparam time CLK_PERIOD = 100;
  localparam int  TIMEOUT    = 200;  // Cycles allowed for any single wait

  typedef struct packed {
    lane_word_t result;
    status_t    status;
    tag_t       tag;
    int         seq;
  } expect_t;

  logic                  clk_i = 1'b0;
  logic                  rst_n_i;
  lane_word_t            operand_a_i;
  lane_word_t            operand_b_i;
  operation_e            op_i;
  fp_format_e            fmt_i;
  logic                  vectorial_op_i;
  logic [`NUM_LANES-1:0] simd_mask_i;
  tag_t                  tag_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  lane_word_t            result_o;
  status_t               status_o;
  tag_t                  tag_o;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic                  busy_o;

  expect_t pending [$];  // Issued operations in order
  time     accept_at [int];
  time     output_at [int];
  int      seq_count = 0;
  int      error_count = 0;
  int      check_count = 0;
  int      test_count = 0;
  int      test_errors = 0;
  bit      stim_done;

  fp_slice_top dut0 (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // --------------------
  // Reference model
  // --------------------
  // One element of 16 or 32 bits as {invalid, value}
  function automatic logic [32:0] element_ref(logic [31:0] a, logic [31:0] b, operation_e op,
                                              bit half);
    logic [31:0] sign_mask;
    logic [31:0] mag_mask;
    logic [31:0] inf;
    logic [31:0] quiet;
    logic [31:0] sign;
    logic        a_nan;
    logic        b_nan;
    logic        nv;
    longint      key_a;
    longint      key_b;
    sign_mask = half ? 32'h8000 : 32'h8000_0000;
    mag_mask  = sign_mask - 1;
    inf       = half ? 32'h7c00 : 32'h7f80_0000;
    quiet     = half ? 32'h0200 : 32'h0040_0000;
    a_nan     = (a & mag_mask) > inf;  // Above infinity means NaN
    b_nan     = (b & mag_mask) > inf;
    if (op == SGNJ || op == SGNJN || op == SGNJX) begin
      sign = (op == SGNJ) ? b : (op == SGNJN) ? ~b : a ^ b;
      return {1'b0, (a & mag_mask) | (sign & sign_mask)};
    end
    nv = (a_nan && (a & quiet) == 0) || (b_nan && (b & quiet) == 0);
    if (a_nan && b_nan) return {nv, half ? 32'h7e00 : 32'h7fc0_0000};
    if (a_nan) return {nv, b};
    if (b_nan) return {nv, a};
    // Minus zero maps to -1 and sorts below plus zero
    key_a = (a & sign_mask) != 0 ? -longint'(a & mag_mask) - 1 : longint'(a & mag_mask);
    key_b = (b & sign_mask) != 0 ? -longint'(b & mag_mask) - 1 : longint'(b & mag_mask);
    if (op == MIN) return {nv, (key_a <= key_b) ? a : b};
    return {nv, (key_a >= key_b) ? a : b};
  endfunction

  function automatic expect_t reference_result(lane_word_t a, lane_word_t b, operation_e op,
                                               fp_format_e fmt, logic vec, logic [1:0] mask);
    expect_t     e;
    logic [32:0] r0;
    logic [32:0] r1;
    e = '0;
    if (fmt == FP32) begin
      r0          = element_ref(a, b, op, 1'b0);
      e.result    = r0[31:0];
      e.status.nv = r0[32] & mask[0];
    end else begin
      r0          = element_ref({16'h0, a[15:0]}, {16'h0, b[15:0]}, op, 1'b1);
      r1          = element_ref({16'h0, a[31:16]}, {16'h0, b[31:16]}, op, 1'b1);
      e.result    = vec ? {r1[15:0], r0[15:0]} : {16'hffff, r0[15:0]};
      e.status.nv = (r0[32] & mask[0]) | (vec & r1[32] & mask[1]);
    end
    return e;
  endfunction

  // --------------------
  // Checks
  // --------------------
  task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_result(lane_word_t got, lane_word_t exp);
    report_value("result_o", got, exp);
  endtask

  task automatic check_status(status_t got, status_t exp);
    report_value("status_o", 32'(got), 32'(exp));
  endtask

  task automatic check_tag(tag_t got, tag_t exp);
    report_value("tag_o", 32'(got), 32'(exp));
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    report_value(name, 32'(got), 32'(exp));
  endtask

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Finished with errors");
    $finish;
  endtask

  // One expectation is taken per output transfer
  always @(posedge clk_i) begin
    expect_t e;
    if (rst_n_i && out_valid_o && out_ready_i) begin
      if (pending.size() == 0) begin
        error_count++;
        $display("Output transfer at %0t with no operation pending", $time);
      end else begin
        e = pending.pop_front();
        output_at[e.seq] = $time;
        check_result(result_o, e.result);
        check_status(status_o, e.status);
        check_tag(tag_o, e.tag);
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  // Starts at a falling edge and returns at the falling edge after acceptance
  task automatic send_op(lane_word_t a, lane_word_t b, operation_e op, fp_format_e fmt,
                         logic vec, logic [1:0] mask);
    expect_t e;
    int      cycles;
    e     = reference_result(a, b, op, fmt, vec, mask);
    e.tag = tag_t'(seq_count);
    e.seq = seq_count;
    pending.push_back(e);
    operand_a_i    = a;
    operand_b_i    = b;
    op_i           = op;
    fmt_i          = fmt;
    vectorial_op_i = vec;
    simd_mask_i    = mask;
    tag_i          = e.tag;
    in_valid_i     = 1'b1;
    cycles         = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) abort_run("Timeout: an input was never accepted by the slice");
    end while (!in_ready_o);
    accept_at[seq_count] = $time;
    seq_count++;
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic finish_test(string name);
    int cycles;
    cycles = 0;
    while (pending.size() != 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) abort_run("Timeout: results are still missing after draining");
    end
    test_count++;
    $display("Test %0d %s done with %0d errors", test_count, name, error_count - test_errors);
    test_errors = error_count;
  endtask

  // FP16 mix of random values, signed zeros, quiet NaNs and signalling NaNs
  function automatic logic [15:0] special_half();
    logic [15:0] r;
    r = 16'($urandom);
    case ($urandom % 5)
      0: return {r[15], 15'h0};
      1: return {r[15], 5'h1f, 1'b1, r[8:0]};
      2: return {r[15], 5'h1f, 1'b0, r[8:1], 1'b1};  // Payload kept nonzero
      default: return r;
    endcase
  endfunction

  initial begin
    int unsigned seed;
    int          cycles;
    int          first;
    fp_format_e  fmt;
    lane_word_t  a;
    $timeformat(-9, 0, " ns", 0);
    seed           = $urandom(32'h14c66858);
    rst_n_i        = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    op_i           = SGNJ;
    fmt_i          = FP32;
    vectorial_op_i = 1'b0;
    simd_mask_i    = '0;
    tag_i          = '0;
    in_valid_i     = 1'b0;
    out_ready_i    = 1'b1;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    check_flag("out_valid_o", out_valid_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("in_ready_o", in_ready_o, 1'b1);
    finish_test("reset");

    // Vectorial FP32 requests must behave as scalar
    for (int i = 0; i < 24; i++) begin
      fmt = (i % 2 == 1) ? FP16 : FP32;
      send_op($urandom, $urandom, operation_e'(i % 3), fmt, fmt == FP32 && i[2], 2'b11);
    end
    finish_test("sign injection");

    for (int i = 0; i < 40; i++) begin
      send_op({special_half(), special_half()}, {special_half(), special_half()},
              (i % 2 == 1) ? MAX : MIN, FP16, 1'b1, 2'($urandom));
    end
    finish_test("vector min/max");

    for (int m = 0; m < 4; m++) begin
      for (int p = 1; p < 4; p++) begin
        a = {p[1] ? 16'h7d01 : 16'h3c00, p[0] ? 16'hfd55 : 16'hc000};  // sNaN where p says
        send_op(a, 32'h4000_4000, MIN, FP16, 1'b1, m[1:0]);
      end
    end
    finish_test("status mask");

    stim_done = 1'b0;
    fork
      begin
        for (int i = 0; i < 60; i++) begin
          send_op($urandom, $urandom, operation_e'($urandom % 5), fp_format_e'($urandom % 2),
                  1'($urandom), 2'($urandom));
        end
        stim_done = 1'b1;
      end
      begin
        cycles = 0;
        while (!stim_done) begin
          @(negedge clk_i);
          out_ready_i = ($urandom % 3) != 0;
          cycles++;
          if (cycles > 60 * TIMEOUT) abort_run("Timeout: back-pressure stimulus did not finish");
        end
      end
    join
    out_ready_i = 1'b1;
    finish_test("back-pressure");

    first = seq_count;
    for (int i = 0; i < 16; i++) begin
      send_op($urandom, $urandom, SGNJX, FP32, 1'b0, 2'b01);
      if (i % 4 == 3) repeat (2) @(negedge clk_i);  // Idle gap between bursts
    end
    finish_test("latency drain");
    for (int s = first; s < seq_count; s++) begin
      if (output_at[s] - accept_at[s] != `NUM_PIPE_REGS * CLK_PERIOD) begin
        error_count++;
        $display("Operation %0d left %0t after acceptance, expected %0d cycles",
                 s, output_at[s] - accept_at[s], `NUM_PIPE_REGS);
      end
    end
    finish_test("latency");

    error_count += dut0.i_sva.failed_checks;
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
